//--- bench/backup_tb.sv
`timescale 1ns/1ps

// Testbench for the backup-RAM path
// The block host model serves a pseudo-random image and logs each sector
// All waits are bounded and the first mismatch ends the run

module backup_tb;
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	localparam int img_words    = total_sectors * words_per_sector;
	localparam int quiet_cycles = 100;
	localparam int xfer_timeout = 5000;

	logic      clk_sys;
	logic      reset;
	host_cmd_t host;
	mount_t    mount;
	logic      cart_has_save;
	cram_req_t cram1;
	cram_req_t cram2;
	word_t     cram1_q;
	word_t     cram2_q;
	sd_buf_t   sd_buf;
	sd_req_t   sd_req;
	word_t     sd_buff_din;
	logic      sav_pending;
	logic      bk_loading;

	word_t       image    [img_words];
	word_t       saved    [img_words];
	word_t       expected [img_words];
	lba_t        lba_log  [total_sectors * 8];
	int          lba_count;
	logic [16:0] lfsr;
	string       test_name;

	backup_top backup_top_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host          (host),
		.mount         (mount),
		.cart_has_save (cart_has_save),
		.cram1         (cram1),
		.cram2         (cram2),
		.cram1_q       (cram1_q),
		.cram2_q       (cram2_q),
		.sd_buf        (sd_buf),
		.sd_req        (sd_req),
		.sd_buff_din   (sd_buff_din),
		.sav_pending   (sav_pending),
		.bk_loading    (bk_loading)
	);

	sd_card_model sd_card_model_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sd_req      (sd_req),
		.sd_buff_din (sd_buff_din),
		.image       (image),
		.sd_buf      (sd_buf),
		.lba_count   (lba_count),
		.lba_log     (lba_log),
		.saved       (saved)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_value(input string label, input logic [31:0] exp,
		input logic [31:0] act);
		stop_run($sformatf("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
			test_name, label, exp, act));
	endtask

	task automatic check_eq(input string label, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act == exp) else fail_value(label, exp, act);
	endtask

	// The host protocol never allows both directions at once
	no_rd_wr_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_req.rd && sd_req.wr))
		else fail_value("rd and wr together", 0, 1);

	rd_only_loading: assert property (@(posedge clk_sys) disable iff (reset)
		sd_req.rd |-> bk_loading)
		else fail_value("bk_loading during rd", 1, 0);

	wr_not_loading: assert property (@(posedge clk_sys) disable iff (reset)
		sd_req.wr |-> !bk_loading)
		else fail_value("bk_loading during wr", 0, 1);

	////////////////////
	// Stimulus helpers
	////////////////////

	// Fibonacci LFSR with taps 17 and 14, one step per bit
	function automatic word_t random_word();
		logic  fb;
		word_t w;
		w = '0;
		for (int i = 0; i < word_w; i++) begin
			fb   = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			w    = {w[word_w-2:0], fb};
		end
		return w;
	endfunction

	task automatic write_core(input int core, input bank_addr_t addr, input word_t data);
		@(negedge clk_sys);
		if (core == 0) begin
			cram1.addr = addr;
			cram1.data = data;
			cram1.wr   = 1'b1;
		end else begin
			cram2.addr = addr;
			cram2.data = data;
			cram2.wr   = 1'b1;
		end
		expected[core * bank_words + int'(addr)] = data;
		@(negedge clk_sys);
		cram1.wr = 1'b0;
		cram2.wr = 1'b0;
	endtask

	task automatic read_core(input int core, input bank_addr_t addr, output word_t q);
		@(negedge clk_sys);
		if (core == 0) begin
			cram1.addr = addr;
			cram1.rd   = 1'b1;
		end else begin
			cram2.addr = addr;
			cram2.rd   = 1'b1;
		end
		@(negedge clk_sys);
		q        = (core == 0) ? cram1_q : cram2_q;
		cram1.rd = 1'b0;
		cram2.rd = 1'b0;
	endtask

	task automatic wait_start();
		int n;
		n = 0;
		while (!(sd_req.rd | sd_req.wr)) begin
			if (n == 50)
				stop_run($sformatf("%s: no sector request arrived", test_name));
			n++;
			@(negedge clk_sys);
		end
	endtask

	// Done means every sector was served and the sequencer is idle again
	task automatic wait_done(input int start);
		int n;
		n = 0;
		while (lba_count < start + total_sectors || sd_buf.ack || backup_top_inst.busy) begin
			if (n == xfer_timeout)
				stop_run($sformatf("%s: transfer did not finish", test_name));
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_load_end();
		int n;
		n = 0;
		while (bk_loading) begin
			if (n == xfer_timeout)
				stop_run($sformatf("%s: bk_loading stayed high", test_name));
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic expect_quiet();
		int start;
		start = lba_count;
		for (int n = 0; n < quiet_cycles; n++) begin
			@(negedge clk_sys);
			check_eq("sd request", 0, {sd_req.rd, sd_req.wr});
		end
		check_eq("sectors served", start, lba_count);
	endtask

	task automatic check_sectors(input int start);
		check_eq("sector count", total_sectors, lba_count - start);
		for (int i = 0; i < total_sectors; i++)
			check_eq($sformatf("lba of sector %0d", i), i, lba_log[start + i]);
	endtask

	task automatic check_saved();
		for (int i = 0; i < img_words; i++)
			check_eq($sformatf("saved word %0d", i), expected[i], saved[i]);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		word_t w;
		int    start;

		host          = '0;
		mount         = '0;
		cart_has_save = 1'b0;
		cram1         = '0;
		cram2         = '0;
		reset         = 1'b1;
		lfsr          = 17'd67690;
		test_name     = "reset_idle";
		for (int i = 0; i < img_words; i++)
			image[i] = random_word();

		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_eq("sd_req.rd", 0, sd_req.rd);
		check_eq("sd_req.wr", 0, sd_req.wr);
		check_eq("sav_pending", 0, sav_pending);
		check_eq("bk_loading", 0, bk_loading);

		// Writable image mounted during a download, no cart save flag
		test_name = "mount_autoload";
		mount = '{downloading: 1'b1, img_mounted: 1'b1, img_readonly: 1'b0,
			img_size: 32'h0000_2000};
		repeat (4) @(negedge clk_sys);
		mount.downloading = 1'b0;
		start = lba_count;
		wait_start();
		check_eq("bk_loading at start", 1, bk_loading);
		wait_load_end();
		check_sectors(start);
		check_eq("ack at load end", 0, sd_buf.ack);
		for (int i = 0; i < img_words; i++)
			expected[i] = image[i];
		for (int i = 0; i < img_words; i++) begin
			read_core(i / bank_words, bank_addr_t'(i % bank_words), w);
			check_eq($sformatf("core %0d word %0d", i / bank_words, i % bank_words),
				expected[i], w);
		end

		test_name = "pending_flag";
		w = random_word();
		write_core(0, 6'd5, w);
		check_eq("sav_pending without save", 0, sav_pending);
		cart_has_save = 1'b1;
		host.osd_open = 1'b1;
		w = random_word();
		write_core(1, 6'd40, w);
		check_eq("sav_pending with osd open", 0, sav_pending);
		host.osd_open = 1'b0;
		w = random_word();
		write_core(0, 6'd17, w);
		check_eq("sav_pending after write", 1, sav_pending);

		test_name = "manual_save";
		w = random_word();
		write_core(1, 6'd63, w);
		start = lba_count;
		host.save_cmd = 1'b1;
		@(negedge clk_sys);
		host.save_cmd = 1'b0;
		wait_start();
		check_eq("sd_req.wr", 1, sd_req.wr);
		wait_done(start);
		check_sectors(start);
		check_saved();
		check_eq("sav_pending", 0, sav_pending);

		test_name = "autosave";
		w = random_word();
		write_core(1, 6'd3, w);
		check_eq("sav_pending", 1, sav_pending);
		host.osd_open = 1'b1;
		expect_quiet();
		host.osd_open = 1'b0;
		host.autosave = 1'b1;
		@(negedge clk_sys);
		host.osd_open = 1'b1;
		start = lba_count;
		wait_start();
		wait_done(start);
		check_sectors(start);
		check_saved();
		check_eq("sav_pending", 0, sav_pending);
		host.osd_open = 1'b0;
		host.autosave = 1'b0;

		// Read-only image leaves save disabled after the new download
		test_name = "readonly_lockout";
		@(negedge clk_sys);
		mount.downloading  = 1'b1;
		mount.img_readonly = 1'b1;
		repeat (4) @(negedge clk_sys);
		mount.downloading = 1'b0;
		expect_quiet();
		host.load_cmd = 1'b1;
		@(negedge clk_sys);
		host.load_cmd = 1'b0;
		expect_quiet();

		$display("All checks passed");
		$finish;
	end

endmodule

//--- bench/sd_card_model.sv
`timescale 1ns/1ps

// SD block host model holding one full save image
// Answers rd with buffer writes and wr with buffer reads, one sector at a time
// Drives its outputs on the falling clock edge

module sd_card_model (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  bk_ctrl_pkg::sd_req_t sd_req,
	input  bk_geom_pkg::word_t   sd_buff_din,
	input  bk_geom_pkg::word_t   image [bk_geom_pkg::total_sectors * bk_geom_pkg::words_per_sector],
	output bk_ctrl_pkg::sd_buf_t sd_buf,
	output int                   lba_count,
	output bk_geom_pkg::lba_t    lba_log [bk_geom_pkg::total_sectors * 8],
	output bk_geom_pkg::word_t   saved [bk_geom_pkg::total_sectors * bk_geom_pkg::words_per_sector]
);
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	// Cycles the host lets a request sit before it answers
	localparam int ack_delay = 3;

	logic active;
	logic is_load;
	lba_t cur_lba;
	int   cnt;
	int   delay;

	////////////////////
	// Sector service
	////////////////////

	always @(negedge clk_sys) begin
		if (reset) begin
			sd_buf    <= '0;
			active    <= 1'b0;
			is_load   <= 1'b0;
			cur_lba   <= '0;
			cnt       <= 0;
			delay     <= 0;
			lba_count <= 0;
		end else if (!active) begin
			if ((sd_req.rd | sd_req.wr) & ~sd_buf.ack) begin
				if (delay < ack_delay) begin
					delay <= delay + 1;
				end else begin
					delay   <= 0;
					active  <= 1'b1;
					is_load <= sd_req.rd;
					cur_lba <= sd_req.lba;
					cnt     <= 0;
					if (lba_count < $size(lba_log))
						lba_log[lba_count] <= sd_req.lba;
					lba_count <= lba_count + 1;

					// First word goes out together with ack
					sd_buf.ack  <= 1'b1;
					sd_buf.addr <= '0;
					sd_buf.wr   <= sd_req.rd;
					sd_buf.data <= image[{sd_req.lba, word_addr_t'(0)}];
				end
			end
		end else begin
			// Read data belongs to the address presented one cycle earlier
			if (!is_load)
				saved[{cur_lba, word_addr_t'(cnt)}] <= sd_buff_din;

			if (cnt == words_per_sector - 1) begin
				sd_buf <= '0;
				active <= 1'b0;
			end else begin
				cnt         <= cnt + 1;
				sd_buf.addr <= word_addr_t'(cnt + 1);
				sd_buf.data <= image[{cur_lba, word_addr_t'(cnt + 1)}];
			end
		end
	end

endmodule

//--- files.f
logic/bk_geom_pkg.sv
logic/bk_ctrl_pkg.sv
logic/save_monitor.sv
logic/backup_ram.sv
logic/sector_sequencer.sv
logic/backup_top.sv
bench/sd_card_model.sv
bench/backup_tb.sv

//--- logic/backup_ram.sv
`timescale 1ns/1ps

// Battery RAM with one bank per core
// Each bank has a core port and a shared sector port
// Reads on both ports have one cycle of latency
// Sector writes win over core writes to the same word

module backup_ram (
	input  logic                   clk_sys,
	input  bk_ctrl_pkg::cram_req_t cram1,
	input  bk_ctrl_pkg::cram_req_t cram2,
	output bk_geom_pkg::word_t     cram1_q,
	output bk_geom_pkg::word_t     cram2_q,
	input  bk_geom_pkg::lba_t      lba,
	input  bk_ctrl_pkg::sd_buf_t   sd_buf,
	output bk_geom_pkg::word_t     sd_buff_din
);
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	cram_req_t         core_req [num_cores];
	word_t             core_q   [num_cores];
	word_t             sec_q    [num_cores];
	bank_addr_t        sec_addr;
	logic [core_w-1:0] sec_core;

	assign core_req[0] = cram1;
	assign core_req[1] = cram2;
	assign cram1_q     = core_q[0];
	assign cram2_q     = core_q[1];

	// Upper lba bits pick the bank, lower ones the sector inside it
	assign sec_core = lba[lba_w-1:sec_w];
	assign sec_addr = {lba[sec_w-1:0], sd_buf.addr};

	//////////////////////
	// Banks
	//////////////////////

	for (genvar c = 0; c < num_cores; c++) begin : g_bank
		word_t mem [bank_words];
		word_t q_core;
		word_t q_sec;
		logic  sec_we;

		assign sec_we = sd_buf.wr & sd_buf.ack & (sec_core == c);

		always_ff @(posedge clk_sys) begin
			if (core_req[c].wr)
				mem[core_req[c].addr] <= core_req[c].data;
			if (sec_we)
				mem[sec_addr] <= sd_buf.data;

			if (core_req[c].rd)
				q_core <= mem[core_req[c].addr];
			q_sec <= mem[sec_addr];
		end

		assign core_q[c] = q_core;
		assign sec_q[c]  = q_sec;
	end

	// lba holds still for a whole sector so the select needs no register
	assign sd_buff_din = sec_q[sec_core];

endmodule

//--- logic/backup_top.sv
`timescale 1ns/1ps

// Backup-RAM path of the two-core handheld top level
// bk_loading is meant to hold both cores in reset while a save loads
// All inputs are synchronous to clk_sys

module backup_top (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Menu and download side
	input  bk_ctrl_pkg::host_cmd_t host,
	input  bk_ctrl_pkg::mount_t    mount,
	input  logic                   cart_has_save,

	// Core cart RAM ports
	input  bk_ctrl_pkg::cram_req_t cram1,
	input  bk_ctrl_pkg::cram_req_t cram2,
	output bk_geom_pkg::word_t     cram1_q,
	output bk_geom_pkg::word_t     cram2_q,

	// SD block host
	input  bk_ctrl_pkg::sd_buf_t   sd_buf,
	output bk_ctrl_pkg::sd_req_t   sd_req,
	output bk_geom_pkg::word_t     sd_buff_din,

	output logic                   sav_pending,
	output logic                   bk_loading
);
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	logic load_req;
	logic save_req;
	logic busy;
	logic cram_wr_any;

	// Either core dirtying its RAM counts
	assign cram_wr_any = cram1.wr | cram2.wr;

	save_monitor save_monitor_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host          (host),
		.mount         (mount),
		.cart_has_save (cart_has_save),
		.cram_wr_any   (cram_wr_any),
		.busy          (busy),
		.load_req      (load_req),
		.save_req      (save_req),
		.sav_pending   (sav_pending)
	);

	backup_ram backup_ram_inst (
		.clk_sys     (clk_sys),
		.cram1       (cram1),
		.cram2       (cram2),
		.cram1_q     (cram1_q),
		.cram2_q     (cram2_q),
		.lba         (sd_req.lba),
		.sd_buf      (sd_buf),
		.sd_buff_din (sd_buff_din)
	);

	sector_sequencer sector_sequencer_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_req   (load_req),
		.save_req   (save_req),
		.sd_ack     (sd_buf.ack),
		.sd_req     (sd_req),
		.busy       (busy),
		.bk_loading (bk_loading)
	);

endmodule

//--- logic/bk_ctrl_pkg.sv
// Control types for the backup-RAM path
// Menu and mount fields are levels sampled on clk_sys
// SD block host structs follow the plain rd/wr/ack level protocol

package bk_ctrl_pkg;

	// Sequencer state
	typedef enum logic [1:0] {
		xfer_idle,
		xfer_load,
		xfer_save
	} xfer_e;

	// Menu side requests
	typedef struct packed {
		logic load_cmd;
		logic save_cmd;
		logic autosave;
		logic osd_open;
	} host_cmd_t;

	// ROM download and save image mount state
	typedef struct packed {
		logic                   downloading;
		logic                   img_mounted;
		logic                   img_readonly;
		bk_geom_pkg::img_size_t img_size;
	} mount_t;

	// Cart RAM access from one core
	typedef struct packed {
		bk_geom_pkg::bank_addr_t addr;
		bk_geom_pkg::word_t      data;
		logic                    wr;
		logic                    rd;
	} cram_req_t;

	// Sector request towards the block host
	typedef struct packed {
		bk_geom_pkg::lba_t lba;
		logic              rd;
		logic              wr;
	} sd_req_t;

	// Buffer side driven by the block host
	typedef struct packed {
		bk_geom_pkg::word_addr_t addr;
		bk_geom_pkg::word_t      data;
		logic                    wr;
		logic                    ack;
	} sd_buf_t;

endpackage

//--- logic/bk_geom_pkg.sv
// Save-file geometry for the two battery-RAM banks
// All sizes must stay powers of two
// The top lba bit selects the core and the rest picks the sector in its bank

package bk_geom_pkg;

	localparam int word_w           = 16;
	localparam int words_per_sector = 16;
	localparam int sectors_per_core = 4;
	localparam int num_cores        = 2;
	localparam int total_sectors    = sectors_per_core * num_cores;

	// Derived widths
	localparam int word_addr_w = $clog2(words_per_sector);
	localparam int sec_w       = $clog2(sectors_per_core);
	localparam int core_w      = $clog2(num_cores);
	localparam int lba_w       = core_w + sec_w;
	localparam int bank_addr_w = sec_w + word_addr_w;
	localparam int bank_words  = sectors_per_core * words_per_sector;
	localparam int img_size_w  = 32;

	typedef logic [word_addr_w-1:0] word_addr_t;
	typedef logic [lba_w-1:0]       lba_t;
	typedef logic [bank_addr_w-1:0] bank_addr_t;
	typedef logic [word_w-1:0]      word_t;
	typedef logic [img_size_w-1:0]  img_size_t;

	// Final sector of a full transfer
	localparam lba_t last_lba = lba_t'(total_sectors - 1);

endpackage

//--- logic/save_monitor.sv
`timescale 1ns/1ps

// Decides when the save file may be used and when to move it
// Save stays disabled until a writable image is mounted during a download
// Requests are one-cycle pulses and the sequencer ignores them while busy

module save_monitor (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  bk_ctrl_pkg::host_cmd_t host,
	input  bk_ctrl_pkg::mount_t    mount,
	input  logic                   cart_has_save,
	input  logic                   cram_wr_any,
	input  logic                   busy,
	output logic                   load_req,
	output logic                   save_req,
	output logic                   sav_pending
);
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	host_cmd_t old_host;
	logic      old_downloading;
	logic      old_autosave;
	logic      bk_ena;
	logic      sav_supported;
	logic      dl_start;
	logic      dl_end;
	logic      autosave_now;
	logic      load_hit;
	logic      save_hit;

	//////////////////////
	// Edge detection
	//////////////////////

	assign dl_start      = mount.downloading & ~old_downloading;
	assign dl_end        = old_downloading & ~mount.downloading;
	assign sav_supported = cart_has_save & bk_ena;

	// Autosave fires when the menu opens with unsaved data
	assign autosave_now = sav_pending & host.osd_open & host.autosave;

	// End of download restores the save if there is anything to restore
	assign load_hit = (host.load_cmd & ~old_host.load_cmd) |
		(dl_end & (cart_has_save | (|mount.img_size)));

	assign save_hit = (host.save_cmd & ~old_host.save_cmd) |
		(autosave_now & ~old_autosave);

	//////////////////////
	// State
	//////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_host        <= '0;
			old_downloading <= 1'b0;
			old_autosave    <= 1'b0;
			bk_ena          <= 1'b0;
			load_req        <= 1'b0;
			save_req        <= 1'b0;
			sav_pending     <= 1'b0;
		end else begin
			old_host        <= host;
			old_downloading <= mount.downloading;
			old_autosave    <= autosave_now;

			// New ROM invalidates the old save until its image shows up
			if (dl_start)
				bk_ena <= 1'b0;
			if (mount.downloading & mount.img_mounted & ~mount.img_readonly)
				bk_ena <= 1'b1;

			load_req <= bk_ena & load_hit;
			save_req <= bk_ena & save_hit;

			// Writes made with the menu open are not counted
			if (cram_wr_any & ~host.osd_open & sav_supported)
				sav_pending <= 1'b1;
			else if (busy)
				sav_pending <= 1'b0;
		end
	end

endmodule

//--- logic/sector_sequencer.sv
`timescale 1ns/1ps

// Walks every sector of both banks against the SD block host
// A transfer always covers all sectors in ascending order
// The host may take as long as it likes per sector
// Requests arriving during a transfer are dropped

module sector_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 load_req,
	input  logic                 save_req,
	input  logic                 sd_ack,
	output bk_ctrl_pkg::sd_req_t sd_req,
	output logic                 busy,
	output logic                 bk_loading
);
	import bk_geom_pkg::*;
	import bk_ctrl_pkg::*;

	xfer_e state;
	logic  old_ack;
	logic  ack_rise;
	logic  ack_fall;
	logic  last_sector;

	//////////////////////
	// Ack edges
	//////////////////////

	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = old_ack & ~sd_ack;
	assign last_sector = (sd_req.lba == last_lba);

	assign busy       = (state != xfer_idle);
	assign bk_loading = (state == xfer_load);

	//////////////////////
	// FSM
	//////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= xfer_idle;
			old_ack <= 1'b0;
			sd_req  <= '0;
		end else begin
			old_ack <= sd_ack;

			case (state)
				xfer_idle: begin
					// Load wins when both show up together
					if (load_req) begin
						state      <= xfer_load;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b1;
						sd_req.wr  <= 1'b0;
					end else if (save_req) begin
						state      <= xfer_save;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b0;
						sd_req.wr  <= 1'b1;
					end
				end

				xfer_load, xfer_save: begin
					// Host took the request
					if (ack_rise) begin
						sd_req.rd <= 1'b0;
						sd_req.wr <= 1'b0;
					end

					// Sector done, move on or finish
					if (ack_fall) begin
						if (last_sector) begin
							state <= xfer_idle;
						end else begin
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= (state == xfer_load);
							sd_req.wr  <= (state == xfer_save);
						end
					end
				end

				default: begin
					state <= xfer_idle;
				end
			endcase
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the backup-RAM testbench with Verilator and runs it
# The run counts as failed when the log is missing or holds the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module backup_tb \
	-f files.f -o backup_sim &&
	./obj_dir/backup_sim > sim.log 2>&1

cat sim.log 2>/dev/null
test -s sim.log && ! grep -q "Checks failed" sim.log && echo "PASS" ||
	{ echo "FAIL"; exit 1; }
